//--- all.f
+incdir+hw
hw/swb_pkg.sv
hw/flow_pkg.sv
hw/swb.sv
hw/swb_group.sv
hw/rob_alloc.sv
hw/rd_reorder_top.sv
testbench/tb_rd_reorder.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       := tb_rd_reorder
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_rd_reorder.sv
`timescale 1ns/100ps

`include "swb_cfg.svh"

module tb_rd_reorder;

   localparam int RST_CYCLES = 10;
   // command count summed over all tests below
   localparam int TOTAL_CMDS = 257;

   logic                clk;
   logic                i_arst_n;
   logic                i_cmd_valid;
   swb_pkg::bank_id_t   i_cmd_bank_id;
   logic                i_rc_valid;
   swb_pkg::rob_id_t    i_rc_rob_id;
   swb_pkg::bank_id_t   i_rc_bank_id;
   swb_pkg::data_t      i_rc_data;
   logic                i_ch_ready;
   logic                o_cmd_ready;
   logic                o_mem_req_valid;
   swb_pkg::bank_id_t   o_mem_req_bank_id;
   swb_pkg::rob_id_t    o_mem_req_rob_id;
   logic                o_ch_valid;
   swb_pkg::data_t      o_ch_data;

   int seed = 32'h2bc1f8d7;
   int errors = 0;
   int words = 0;
   int stalls = 0;
   int cmd_cnt = 0;
   int req_cnt = 0;
   logic rdy_random = 1'b0;
   logic auto_return = 1'b0;
   logic held = 1'b0;
   swb_pkg::data_t held_data;

   // expected channel words, expected requests, next slot per bank
   swb_pkg::data_t    exp_q[$];
   swb_pkg::bank_id_t exp_bank_q[$];
   swb_pkg::rob_id_t  exp_rob_q[$];
   swb_pkg::swb_id_t  exp_slot [`SWB_BANKS];

   // bank model pool of outstanding requests
   swb_pkg::rob_id_t  pend_rob[$];
   swb_pkg::bank_id_t pend_bank[$];
   int                pend_idx[$];

   rd_reorder_top UUT (
      .clk               (clk),
      .i_arst_n          (i_arst_n),
      .i_cmd_valid       (i_cmd_valid),
      .i_cmd_bank_id     (i_cmd_bank_id),
      .i_rc_valid        (i_rc_valid),
      .i_rc_rob_id       (i_rc_rob_id),
      .i_rc_bank_id      (i_rc_bank_id),
      .i_rc_data         (i_rc_data),
      .i_ch_ready        (i_ch_ready),
      .o_cmd_ready       (o_cmd_ready),
      .o_mem_req_valid   (o_mem_req_valid),
      .o_mem_req_bank_id (o_mem_req_bank_id),
      .o_mem_req_rob_id  (o_mem_req_rob_id),
      .o_ch_valid        (o_ch_valid),
      .o_ch_data         (o_ch_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // payload for the n-th command
   function automatic swb_pkg::data_t word_for(input int idx);
      logic [31:0] k;
      k = 32'(idx);
      return {k ^ 32'hc0de0000, ~k, k * 32'h9e3779b9, k + 32'h1000};
   endfunction

   task automatic check_val(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
      if (exp !== act) begin
         errors++;
         $display("error %s expected %0h got %0h at %0t", name, exp, act, $time);
      end
   endtask

   // callers sit 5 ns after a rising edge
   task automatic send_cmd(input swb_pkg::bank_id_t bank);
      i_cmd_valid   = 1'b1;
      i_cmd_bank_id = bank;
      @(negedge clk);
      while (o_cmd_ready !== 1'b1) begin
         @(negedge clk);
      end
      @(posedge clk);
      #5;
      i_cmd_valid = 1'b0;
      exp_bank_q.push_back(bank);
      // bank number weighs one full set of slots
      exp_rob_q.push_back(swb_pkg::rob_id_t'(int'(bank) * `SWB_DEPTH + int'(exp_slot[bank])));
      exp_slot[bank] = exp_slot[bank] + 1'b1;
      exp_q.push_back(word_for(cmd_cnt));
      cmd_cnt++;
   endtask

   task automatic drive_slot(input int pos);
      i_rc_valid   = 1'b1;
      i_rc_rob_id  = pend_rob[pos];
      i_rc_bank_id = pend_bank[pos];
      i_rc_data    = word_for(pend_idx[pos]);
      pend_rob.delete(pos);
      pend_bank.delete(pos);
      pend_idx.delete(pos);
   endtask

   task automatic return_one(input int pos);
      drive_slot(pos);
      @(posedge clk);
      #5;
      i_rc_valid = 1'b0;
   endtask

   task automatic return_random();
      return_one(int'({$random(seed)} % pend_rob.size()));
   endtask

   task automatic wait_pool(input int n);
      while (pend_rob.size() < n) begin
         @(posedge clk);
         #5;
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #5;
      end
      // credit pulse and counter update trail the last handshake
      repeat (3) begin
         @(posedge clk);
         #5;
      end
   endtask

   // request monitor, also feeds the bank model
   always @(negedge clk) begin
      if (o_mem_req_valid === 1'b1) begin
         if (exp_bank_q.size() == 0) begin
            errors++;
            $display("memory request seen with no command accepted at %0t", $time);
         end else begin
            check_val("o_mem_req_bank_id", exp_bank_q.pop_front(), o_mem_req_bank_id);
            check_val("o_mem_req_rob_id", exp_rob_q.pop_front(), o_mem_req_rob_id);
         end
         pend_rob.push_back(o_mem_req_rob_id);
         pend_bank.push_back(o_mem_req_bank_id);
         pend_idx.push_back(req_cnt);
         req_cnt++;
      end
   end

   // channel monitor, handshake happens on the next rising edge
   always @(negedge clk) begin
      if (held) begin
         check_val("o_ch_valid", 1'b1, o_ch_valid);
         check_val("o_ch_data", held_data, o_ch_data);
      end
      held = 1'b0;
      if (o_ch_valid === 1'b1) begin
         if (i_ch_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("channel word %0h arrived with none expected", o_ch_data);
            end else begin
               check_val("o_ch_data", exp_q.pop_front(), o_ch_data);
               words++;
            end
         end else begin
            held      = 1'b1;
            held_data = o_ch_data;
            stalls++;
         end
      end
   end

   always begin
      @(posedge clk);
      #5;
      if (rdy_random) begin
         i_ch_ready = ({$random(seed)} % 2) == 0;
      end else begin
         i_ch_ready = 1'b1;
      end
   end

   // background returns for the long run
   always begin
      @(posedge clk);
      #5;
      if (auto_return) begin
         if (pend_rob.size() != 0 && ({$random(seed)} % 2) == 0) begin
            drive_slot(int'({$random(seed)} % pend_rob.size()));
         end else begin
            i_rc_valid = 1'b0;
         end
      end
   end

   task automatic reset_and_req_ids();
      @(negedge clk);
      check_val("o_cmd_ready", 1'b1, o_cmd_ready);
      check_val("o_mem_req_valid", 1'b0, o_mem_req_valid);
      check_val("o_ch_valid", 1'b0, o_ch_valid);
      @(posedge clk);
      #5;
      for (int i = 0; i < 8; i++) begin
         send_cmd(swb_pkg::bank_id_t'(i % 4));
      end
      wait_pool(8);
      while (pend_rob.size() != 0) begin
         return_one(0);
      end
      wait_drain();
   endtask

   task automatic reorder_across_banks();
      for (int i = 0; i < 12; i++) begin
         send_cmd(swb_pkg::bank_id_t'((i * 3 + 1) % 4));
      end
      wait_pool(12);
      // newest first
      while (pend_rob.size() != 0) begin
         return_one(pend_rob.size() - 1);
      end
      wait_drain();
      for (int i = 0; i < 12; i++) begin
         send_cmd(swb_pkg::bank_id_t'(i % 4));
      end
      wait_pool(12);
      while (pend_rob.size() != 0) begin
         return_random();
      end
      wait_drain();
   endtask

   task automatic channel_backpressure();
      int stalls_before;
      stalls_before = stalls;
      rdy_random    = 1'b1;
      for (int i = 0; i < 16; i++) begin
         send_cmd(swb_pkg::bank_id_t'((i * 5 + 2) % 4));
      end
      wait_pool(16);
      while (pend_rob.size() != 0) begin
         return_random();
      end
      wait_drain();
      rdy_random = 1'b0;
      if (stalls == stalls_before) begin
         errors++;
         $display("channel never stalled while ready was toggled");
      end
   endtask

   task automatic bank_credit_limit();
      int cycles;
      for (int i = 0; i < `SWB_DEPTH; i++) begin
         send_cmd(2'd2);
      end
      i_cmd_bank_id = 2'd2;
      @(negedge clk);
      check_val("o_cmd_ready", 1'b0, o_cmd_ready);
      for (int b = 0; b < `SWB_BANKS; b++) begin
         @(posedge clk);
         #5;
         i_cmd_bank_id = swb_pkg::bank_id_t'(b);
         @(negedge clk);
         check_val("o_cmd_ready", (b != 2), o_cmd_ready);
      end
      @(posedge clk);
      #5;
      send_cmd(2'd0);
      wait_pool(`SWB_DEPTH + 1);
      // oldest bank 2 entry sits at the order queue head
      return_one(0);
      i_cmd_bank_id = 2'd2;
      cycles = 0;
      @(negedge clk);
      while (o_cmd_ready !== 1'b1 && cycles < 20) begin
         cycles++;
         @(negedge clk);
      end
      if (cycles == 20) begin
         errors++;
         $display("bank 2 stayed without credit after a word drained");
      end
      @(posedge clk);
      #5;
      while (pend_rob.size() != 0) begin
         return_one(pend_rob.size() - 1);
      end
      wait_drain();
   endtask

   task automatic long_random_run();
      rdy_random  = 1'b1;
      auto_return = 1'b1;
      for (int i = 0; i < 200; i++) begin
         send_cmd(swb_pkg::bank_id_t'($random(seed)));
      end
      wait_drain();
      auto_return = 1'b0;
      rdy_random  = 1'b0;
      if (pend_rob.size() != 0 || exp_bank_q.size() != 0) begin
         errors++;
         $display("requests left over after the long run");
      end
      check_val("o_ch_valid", 1'b0, o_ch_valid);
   endtask

   initial begin
      repeat (RST_CYCLES + TOTAL_CMDS * 200) @(posedge clk);
      $display("timeout, the channel stopped delivering words");
      $display("errors: %0d, words checked: %0d", errors, words);
      $display("Test failed");
      $finish;
   end

   initial begin
      i_arst_n      = 1'b0;
      i_cmd_valid   = 1'b0;
      i_cmd_bank_id = '0;
      i_rc_valid    = 1'b0;
      i_rc_rob_id   = '0;
      i_rc_bank_id  = '0;
      i_rc_data     = '0;
      i_ch_ready    = 1'b1;
      for (int b = 0; b < `SWB_BANKS; b++) begin
         exp_slot[b] = '0;
      end
      repeat (RST_CYCLES) @(posedge clk);
      #5;
      i_arst_n = 1'b1;
      reset_and_req_ids();
      reorder_across_banks();
      channel_backpressure();
      bank_credit_limit();
      long_random_run();
      $display("errors: %0d, words checked: %0d", errors, words);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- hw/rd_reorder_top.sv
`timescale 1ns/100ps

`include "swb_cfg.svh"

module rd_reorder_top (
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_cmd_valid,
   input  swb_pkg::bank_id_t   i_cmd_bank_id,
   input  logic                i_rc_valid,
   input  swb_pkg::rob_id_t    i_rc_rob_id,
   input  swb_pkg::bank_id_t   i_rc_bank_id,
   input  swb_pkg::data_t      i_rc_data,
   input  logic                i_ch_ready,
   output logic                o_cmd_ready,
   output logic                o_mem_req_valid,
   output swb_pkg::bank_id_t   o_mem_req_bank_id,
   output swb_pkg::rob_id_t    o_mem_req_rob_id,
   output logic                o_ch_valid,
   output swb_pkg::data_t      o_ch_data
);

   // release handshake
   logic                  kob_req;
   logic                  kob_ack;
   swb_pkg::bank_id_t     kob_bank_id;

   // credit return, one bit per bank
   logic [`SWB_BANKS-1:0] crdt_rtn;

   rob_alloc u_rob_alloc (
      .clk               (clk),
      .i_arst_n          (i_arst_n),
      .i_cmd_valid       (i_cmd_valid),
      .i_cmd_bank_id     (i_cmd_bank_id),
      .i_kob_ack         (kob_ack),
      .i_crdt_rtn        (crdt_rtn),
      .o_cmd_ready       (o_cmd_ready),
      .o_mem_req_valid   (o_mem_req_valid),
      .o_mem_req_bank_id (o_mem_req_bank_id),
      .o_mem_req_rob_id  (o_mem_req_rob_id),
      .o_kob_req         (kob_req),
      .o_kob_bank_id     (kob_bank_id)
   );

   swb_group u_swb_group (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_kob_req     (kob_req),
      .i_kob_bank_id (kob_bank_id),
      .i_rc_valid    (i_rc_valid),
      .i_rc_rob_id   (i_rc_rob_id),
      .i_rc_bank_id  (i_rc_bank_id),
      .i_rc_data     (i_rc_data),
      .i_ch_ready    (i_ch_ready),
      .o_kob_ack     (kob_ack),
      .o_ch_valid    (o_ch_valid),
      .o_ch_data     (o_ch_data),
      .o_crdt_rtn    (crdt_rtn)
   );

endmodule

//--- hw/rob_alloc.sv
`timescale 1ns/100ps

`include "swb_cfg.svh"

module rob_alloc (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  logic                   i_cmd_valid,
   input  swb_pkg::bank_id_t      i_cmd_bank_id,
   input  logic                   i_kob_ack,
   input  logic [`SWB_BANKS-1:0]  i_crdt_rtn,
   output logic                   o_cmd_ready,
   output logic                   o_mem_req_valid,
   output swb_pkg::bank_id_t      o_mem_req_bank_id,
   output swb_pkg::rob_id_t       o_mem_req_rob_id,
   output logic                   o_kob_req,
   output swb_pkg::bank_id_t      o_kob_bank_id
);

   localparam int CNT_W = $clog2(`ORD_DEPTH + 1);

   flow_pkg::crdt_cnt_t   crdt      [`SWB_BANKS];
   swb_pkg::swb_id_t      alloc_ptr [`SWB_BANKS];
   logic [`SWB_BANKS-1:0] bank_take;

   // bank ids in command order
   swb_pkg::bank_id_t     ord_q [`ORD_DEPTH];
   flow_pkg::ord_ptr_t    ord_wr_ptr;
   flow_pkg::ord_ptr_t    ord_rd_ptr;
   logic [CNT_W-1:0]      ord_cnt;
   logic                  ord_full;
   logic                  accept;
   logic                  pop;

   assign ord_full      = (ord_cnt == CNT_W'(`ORD_DEPTH));
   assign o_cmd_ready   = (crdt[i_cmd_bank_id] != '0) & ~ord_full;
   assign accept        = i_cmd_valid & o_cmd_ready;

   // queue head drives the release
   assign o_kob_req     = (ord_cnt != '0);
   assign o_kob_bank_id = ord_q[ord_rd_ptr];
   assign pop           = o_kob_req & i_kob_ack;

   always_comb begin
      bank_take = '0;
      bank_take[i_cmd_bank_id] = accept;
   end

   // credits and slot allocation per bank
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int b = 0; b < `SWB_BANKS; b++) begin
            crdt[b]      <= flow_pkg::crdt_cnt_t'(`SWB_DEPTH);
            alloc_ptr[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `SWB_BANKS; b++) begin
            case ({bank_take[b], i_crdt_rtn[b]})
               2'b10:   crdt[b] <= crdt[b] - 1'b1;
               2'b01:   crdt[b] <= crdt[b] + 1'b1;
               default: crdt[b] <= crdt[b];
            endcase
            if (bank_take[b]) begin
               alloc_ptr[b] <= alloc_ptr[b] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_mem_req_valid <= 1'b0;
         ord_wr_ptr      <= '0;
         ord_rd_ptr      <= '0;
         ord_cnt         <= '0;
      end else begin
         o_mem_req_valid <= accept;
         if (accept) begin
            ord_wr_ptr <= ord_wr_ptr + 1'b1;
         end
         if (pop) begin
            ord_rd_ptr <= ord_rd_ptr + 1'b1;
         end
         case ({accept, pop})
            2'b10:   ord_cnt <= ord_cnt + 1'b1;
            2'b01:   ord_cnt <= ord_cnt - 1'b1;
            default: ord_cnt <= ord_cnt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         ord_q[ord_wr_ptr] <= i_cmd_bank_id;
         o_mem_req_bank_id <= i_cmd_bank_id;
         // id is {bank, slot}, zero extended
         o_mem_req_rob_id  <= swb_pkg::rob_id_t'({i_cmd_bank_id, alloc_ptr[i_cmd_bank_id]});
      end
   end

   for (genvar b = 0; b < `SWB_BANKS; b++) begin : g_crdt_chk
      a_crdt_max: assert property (
         @(posedge clk) disable iff (!i_arst_n)
         crdt[b] <= flow_pkg::crdt_cnt_t'(`SWB_DEPTH)
      ) else $error("rob_alloc: credit overflow on bank %0d", b);
   end

   a_pop_not_empty: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_kob_ack |-> o_kob_req
   ) else $error("rob_alloc: order queue popped while empty");

endmodule

//--- hw/swb_group.sv
`timescale 1ns/100ps

`include "swb_cfg.svh"

module swb_group (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  logic                   i_kob_req,
   input  swb_pkg::bank_id_t      i_kob_bank_id,
   input  logic                   i_rc_valid,
   input  swb_pkg::rob_id_t       i_rc_rob_id,
   input  swb_pkg::bank_id_t      i_rc_bank_id,
   input  swb_pkg::data_t         i_rc_data,
   input  logic                   i_ch_ready,
   output logic                   o_kob_ack,
   output logic                   o_ch_valid,
   output swb_pkg::data_t         o_ch_data,
   output logic [`SWB_BANKS-1:0]  o_crdt_rtn
);

   localparam int SLOT_W = $bits(swb_pkg::swb_id_t);

   logic [`SWB_BANKS-1:0] bank_kob_req;
   logic [`SWB_BANKS-1:0] bank_kob_ack;
   logic [`SWB_BANKS-1:0] bank_rc_valid;
   logic [`SWB_BANKS-1:0] bank_ch_valid;
   swb_pkg::data_t        bank_ch_data [`SWB_BANKS];
   swb_pkg::swb_id_t      rc_swb_id;
   logic                  ch_block;

   // slot index is the low part of the reorder id
   assign rc_swb_id = i_rc_rob_id[SLOT_W-1:0];

   // per bank decode
   always_comb begin
      bank_kob_req  = '0;
      bank_rc_valid = '0;
      for (int b = 0; b < `SWB_BANKS; b++) begin
         if (i_kob_bank_id == swb_pkg::bank_id_t'(b)) begin
            bank_kob_req[b] = i_kob_req;
         end
         if (i_rc_bank_id == swb_pkg::bank_id_t'(b)) begin
            bank_rc_valid[b] = i_rc_valid;
         end
      end
   end

   // only the selected bank sees a request
   assign o_kob_ack = |bank_kob_ack;

   for (genvar b = 0; b < `SWB_BANKS; b++) begin : g_bank
      swb u_swb (
         .clk         (clk),
         .i_arst_n    (i_arst_n),
         .i_kob_req   (bank_kob_req[b]),
         .i_rc_valid  (bank_rc_valid[b]),
         .i_rc_swb_id (rc_swb_id),
         .i_rc_data   (i_rc_data),
         .i_ch_ready  (i_ch_ready),
         .i_ch_block  (ch_block),
         .o_kob_ack   (bank_kob_ack[b]),
         .o_ch_valid  (bank_ch_valid[b]),
         .o_ch_data   (bank_ch_data[b]),
         .o_crdt_rtn  (o_crdt_rtn[b])
      );
   end

   // channel merge
   assign o_ch_valid = |bank_ch_valid;
   assign ch_block   = o_ch_valid;

   always_comb begin
      o_ch_data = bank_ch_data[0];
      for (int b = 1; b < `SWB_BANKS; b++) begin
         if (bank_ch_valid[b]) begin
            o_ch_data = bank_ch_data[b];
         end
      end
   end

   a_one_owner: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      $onehot0(bank_ch_valid)
   ) else $error("swb_group: more than one bank drives the channel");

   // returned id must carry the bank it was issued for
   a_rob_bank_match: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_rc_valid |-> ((i_rc_rob_id >> SLOT_W) == swb_pkg::rob_id_t'(i_rc_bank_id))
   ) else $error("swb_group: reorder id does not match completion bank");

endmodule

//--- hw/swb.sv
`timescale 1ns/100ps

`include "swb_cfg.svh"

module swb (
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_kob_req,
   input  logic              i_rc_valid,
   input  swb_pkg::swb_id_t  i_rc_swb_id,
   input  swb_pkg::data_t    i_rc_data,
   input  logic              i_ch_ready,
   input  logic              i_ch_block,
   output logic              o_kob_ack,
   output logic              o_ch_valid,
   output swb_pkg::data_t    o_ch_data,
   output logic              o_crdt_rtn
);

   // slot storage
   swb_pkg::data_t        slot_data [`SWB_DEPTH];
   logic [`SWB_DEPTH-1:0] slot_full;

   // next slot to leave in command order
   swb_pkg::swb_id_t      rd_ptr;

   flow_pkg::ch_state_e   state;
   flow_pkg::ch_state_e   state_nxt;
   logic                  ch_fire;

   // release only when head slot is filled and channel is free
   assign o_kob_ack  = i_kob_req & slot_full[rd_ptr] & ~i_ch_block;

   assign o_ch_valid = (state == flow_pkg::CH_HOLD);
   assign ch_fire    = o_ch_valid & i_ch_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         flow_pkg::CH_IDLE: begin
            if (o_kob_ack) begin
               state_nxt = flow_pkg::CH_HOLD;
            end
         end
         flow_pkg::CH_HOLD: begin
            // word stays put until the channel takes it
            if (i_ch_ready) begin
               state_nxt = flow_pkg::CH_IDLE;
            end
         end
         default: begin
            state_nxt = flow_pkg::CH_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state      <= flow_pkg::CH_IDLE;
         slot_full  <= '0;
         rd_ptr     <= '0;
         o_crdt_rtn <= 1'b0;
      end else begin
         state      <= state_nxt;
         // one credit per drained word, cycle after handshake
         o_crdt_rtn <= ch_fire;

         if (o_kob_ack) begin
            slot_full[rd_ptr] <= 1'b0;
            rd_ptr            <= rd_ptr + 1'b1;
         end

         // completion capture
         if (i_rc_valid) begin
            slot_full[i_rc_swb_id] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rc_valid) begin
         slot_data[i_rc_swb_id] <= i_rc_data;
      end
      if (o_kob_ack) begin
         o_ch_data <= slot_data[rd_ptr];
      end
   end

   // credits upstream must keep a bank from reusing a slot still in use
   a_no_overwrite: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_rc_valid |-> !slot_full[i_rc_swb_id]
   ) else $error("swb: completion written into a full slot");

endmodule

//--- hw/flow_pkg.sv
`include "swb_cfg.svh"

package flow_pkg;

   // must reach SWB_DEPTH itself
   typedef logic [$clog2(`SWB_DEPTH + 1)-1:0] crdt_cnt_t;

   // order queue pointer
   typedef logic [$clog2(`ORD_DEPTH)-1:0] ord_ptr_t;

   // swb output register state
   typedef enum logic {
      CH_IDLE,
      CH_HOLD
   } ch_state_e;

endpackage

//--- hw/swb_pkg.sv
`include "swb_cfg.svh"

package swb_pkg;

   // completion payload
   typedef logic [`DATA_WIDTH-1:0] data_t;

   // reorder id, zero padded above the bank field
   // layout is {zeros, bank, slot}
   typedef logic [`ROB_WIDTH-1:0] rob_id_t;

   // slot index inside one bank
   typedef logic [$clog2(`SWB_DEPTH)-1:0] swb_id_t;

   // bank number
   typedef logic [$clog2(`SWB_BANKS)-1:0] bank_id_t;

endpackage

//--- hw/swb_cfg.svh
`ifndef SWB_CFG_SVH
`define SWB_CFG_SVH

// slots per bank, power of two from 2 to 16
`define SWB_DEPTH 8

// fixed bank count
`define SWB_BANKS 4

// reorder id width
`define ROB_WIDTH 8

// completion word width
`define DATA_WIDTH 128

// one entry per outstanding command across all banks
`define ORD_DEPTH (`SWB_DEPTH * `SWB_BANKS)

`endif
